// File: hw/mbfPkg.sv
`default_nettype none

// geometry of seven-variable monotone Boolean functions
package mbfPkg;

    localparam int tableBits = 128;  // one bit per input vector of seven variables
    localparam int permVars = 4;     // upper variables a b c d
    localparam int chunkBits = 8;    // low three variables span one chunk
    localparam int tagBits = 8;      // request tag width

    // bit n holds f(n) with the upper variables in n[6:3]
    typedef logic [tableBits-1:0] truthTable_t;

    typedef logic [tagBits-1:0] reqTag_t;  // opaque to the engine

endpackage

`default_nettype wire

// File: hw/permCheckPkg.sv
`default_nettype none

// intermediary format and consumer control for the 24-way permutation check
package permCheckPkg;

    localparam int oneThreeBits = 16;  // 4x4 array indexed [location*4+flavor]
    localparam int twoTwoBits = 18;    // 3x6 array indexed [location*6+pair]
    localparam int permCount = 24;     // permutations of a b c d
    localparam int groupCount = 4;     // one group per removed variable
    localparam int queueDepth = 4;     // records held between producer and consumer

    // one intermediary record as it travels through the queue
    typedef struct packed {
        logic sharedAll;                     // chunks 0 and 15 already below top
        logic [oneThreeBits-1:0] oneThree;   // one-var chunk joined with its three-var chunk
        logic [twoTwoBits-1:0] twoTwo;       // pair joined with the complementary pair
        mbfPkg::reqTag_t tag;
    } interRec_t;

    typedef logic [1:0] groupSel_t;  // removed variable 0..3 for a..d

    // two/two pair index per remaining slot
    // pairs are ordered ab ac ad cd bd bc
    localparam int groupMap [groupCount][3] = '{
        '{0, 1, 2},  // a removed
        '{0, 5, 4},  // b removed
        '{5, 1, 3},  // c removed
        '{4, 3, 2}   // d removed
    };

    typedef enum logic {
        idle,  // waiting for a record
        eval   // walking the four groups
    } consState_t;

endpackage

`default_nettype wire

// File: hw/permIntermediaryIf.sv
`default_nettype none

// record path from producer through queue to consumer
interface permIntermediaryIf;
    import permCheckPkg::*;

    logic push;         // write wrRec this cycle
    logic pop;          // consumer takes the head
    logic notEmpty;     // head record present
    interRec_t wrRec;   // record from the producer
    interRec_t rdRec;   // oldest stored record

    modport producer (output push, output wrRec);
    modport queue (input push, input wrRec, input pop, output notEmpty, output rdRec);
    modport consumer (input notEmpty, input rdRec, output pop);

endinterface

`default_nettype wire

// File: hw/permIntermediaryProducer.sv
`default_nettype none

module permIntermediaryProducer (
    input logic clk,
    input logic arstN,
    input logic inStrobe,
    input mbfPkg::truthTable_t top,
    input mbfPkg::truthTable_t bot,
    input logic botValid,
    input mbfPkg::reqTag_t inTag,
    input logic full,
    permIntermediaryIf.producer interBus
);
    import mbfPkg::*;
    import permCheckPkg::*;

    logic [chunkBits-1:0] topParts [2**permVars];  // chunk c holds upper vars == c
    logic [chunkBits-1:0] botParts [2**permVars];
    interRec_t nextRec;
    interRec_t recQ;
    logic pushQ;

    // two-var chunk for pair j in order ab ac ad cd bd bc
    function automatic int pairChunk(input int j);
        case (j)
            0: return 3;    // ab
            1: return 5;    // ac
            2: return 9;    // ad
            3: return 12;   // cd
            4: return 10;   // bd
            default: return 6;  // bc
        endcase
    endfunction

    for (genvar c = 0; c < 2**permVars; c++) begin : gSplit
        assign topParts[c] = top[c*chunkBits +: chunkBits];
        assign botParts[c] = bot[c*chunkBits +: chunkBits];
    end

    always_comb begin
        nextRec.tag = inTag;
        // empty and full chunks map onto themselves under every permutation
        nextRec.sharedAll = botValid & (&({topParts[0], topParts[2**permVars-1]}
            | ~{botParts[0], botParts[2**permVars-1]}));
        // flavor j placed at location i together with the complementary three-var chunk
        for (int i = 0; i < permVars; i++) begin
            for (int j = 0; j < permVars; j++) begin
                nextRec.oneThree[i*4+j] = &({topParts[1 << i], topParts[15 ^ (1 << i)]}
                    | ~{botParts[1 << j], botParts[15 ^ (1 << j)]});
            end
        end
        // pair j at shape i with its complement moving along (ab with cd)
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 6; j++) begin
                nextRec.twoTwo[i*6+j] = &({topParts[pairChunk(i)], topParts[pairChunk(i+3)]}
                    | ~{botParts[pairChunk(j)], botParts[pairChunk((j+3) % 6)]});
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pushQ <= 1'b0;
        end else begin
            pushQ <= inStrobe;  // one cycle from strobe to push
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            recQ <= nextRec;
        end
    end

    assign interBus.push = pushQ;
    assign interBus.wrRec = recQ;

    // source has to hold off while the queue reports full
    assert property (@(posedge clk) disable iff (!arstN) full |-> !inStrobe);

endmodule

`default_nettype wire

// File: hw/permIntermediaryQueue.sv
`default_nettype none

module permIntermediaryQueue (
    input logic clk,
    input logic arstN,
    output logic full,
    permIntermediaryIf.queue interBus
);
    import permCheckPkg::*;

    interRec_t mem [queueDepth];                // circular storage
    logic [$clog2(queueDepth)-1:0] wrPtr;       // next free slot
    logic [$clog2(queueDepth)-1:0] rdPtr;       // oldest record
    logic [$clog2(queueDepth+1)-1:0] count;     // records held
    logic doPop;

    assign doPop = interBus.pop & interBus.notEmpty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (interBus.push) begin
                wrPtr <= wrPtr + 1'b1;  // wraps at depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({interBus.push, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (interBus.push) begin
            mem[wrPtr] <= interBus.wrRec;
        end
    end

    assign interBus.notEmpty = (count != '0);  // registered count only
    assign interBus.rdRec = mem[rdPtr];
    // a pending push already claims the last slot
    assign full = (count == queueDepth) || ((count == queueDepth - 1) && interBus.push);

    // producer keeps to full so the buffer never overruns
    assert property (@(posedge clk) disable iff (!arstN)
        interBus.push |-> (count < queueDepth));

    // consumer only pops a present head
    assert property (@(posedge clk) disable iff (!arstN)
        interBus.pop |-> interBus.notEmpty);

endmodule

`default_nettype wire

// File: hw/permResultConsumer.sv
`default_nettype none

module permResultConsumer (
    input logic clk,
    input logic arstN,
    permIntermediaryIf.consumer interBus,
    output logic outStrobe,
    output logic [permCheckPkg::permCount-1:0] results,
    output mbfPkg::reqTag_t outTag
);
    import permCheckPkg::*;

    consState_t state;
    groupSel_t grp;                    // removed variable under evaluation
    interRec_t recQ;                   // record being evaluated
    logic [permCount-1:0] resQ;
    logic outStrobeQ;
    logic grpShared;                   // shared bit of the reduced problem
    logic [8:0] oneTwo;                // 3x3 array indexed [location*3+flavor]
    logic [5:0] flags6;                // abc acb bac bca cab cba of the remaining three

    // removed variable takes flavor slot 0 so the rest keep their order
    function automatic int swapIdx(input int v, input int g);
        return (v == g) ? 0 : v;
    endfunction

    // shared converter from the 24-way to the 6-way intermediaries
    always_comb begin
        grpShared = recQ.sharedAll & recQ.oneThree[grp];  // removed var at location 0
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < 3; k++) begin
                oneTwo[i*3+k] = recQ.oneThree[4*(i+1) + swapIdx(k+1, int'(grp))]
                    & recQ.twoTwo[6*i + groupMap[grp][k]];
            end
        end
    end

    // shared six-way slice
    assign flags6 = {
        grpShared & oneTwo[0] & oneTwo[4] & oneTwo[8],  // abc
        grpShared & oneTwo[0] & oneTwo[5] & oneTwo[7],  // acb
        grpShared & oneTwo[1] & oneTwo[3] & oneTwo[8],  // bac
        grpShared & oneTwo[1] & oneTwo[5] & oneTwo[6],  // bca
        grpShared & oneTwo[2] & oneTwo[3] & oneTwo[7],  // cab
        grpShared & oneTwo[2] & oneTwo[4] & oneTwo[6]   // cba
    };

    assign interBus.pop = (state == idle) & interBus.notEmpty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            grp <= '0;
            outStrobeQ <= 1'b0;
        end else begin
            outStrobeQ <= 1'b0;
            case (state)
                idle: begin
                    if (interBus.notEmpty) begin
                        state <= eval;
                        grp <= '0;  // start with a removed
                    end
                end
                eval: begin
                    if (grp == groupSel_t'(groupCount - 1)) begin
                        state <= idle;
                        outStrobeQ <= 1'b1;  // all four slices written
                    end else begin
                        grp <= grp + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (interBus.pop) begin
            recQ <= interBus.rdRec;
        end
        if (state == eval) begin
            // group a lands in the top slice
            resQ[(groupCount - 1 - int'(grp)) * 6 +: 6] <= flags6;
        end
    end

    assign outStrobe = outStrobeQ;
    assign results = resQ;
    assign outTag = recQ.tag;  // held until the next pop

    // at least four eval cycles separate two results
    assert property (@(posedge clk) disable iff (!arstN) outStrobe |=> !outStrobe);

endmodule

`default_nettype wire

// File: hw/permCheckTop.sv
`default_nettype none

module permCheckTop (
    input logic clk,
    input logic arstN,
    input logic inStrobe,
    input mbfPkg::truthTable_t top,
    input mbfPkg::truthTable_t bot,
    input logic botValid,
    input mbfPkg::reqTag_t inTag,
    output logic full,
    output logic outStrobe,
    output logic [permCheckPkg::permCount-1:0] results,
    output mbfPkg::reqTag_t outTag
);

    permIntermediaryIf interBus ();  // producer to queue to consumer

    permIntermediaryProducer uProducer (
        .clk(clk),
        .arstN(arstN),
        .inStrobe(inStrobe),
        .top(top),
        .bot(bot),
        .botValid(botValid),
        .inTag(inTag),
        .full(full),
        .interBus(interBus.producer)
    );

    permIntermediaryQueue uQueue (
        .clk(clk),
        .arstN(arstN),
        .full(full),
        .interBus(interBus.queue)
    );

    permResultConsumer uConsumer (
        .clk(clk),
        .arstN(arstN),
        .interBus(interBus.consumer),
        .outStrobe(outStrobe),
        .results(results),
        .outTag(outTag)
    );

endmodule

`default_nettype wire

// File: dv/permCheckRef.svh
`ifndef PERM_CHECK_REF_SVH
`define PERM_CHECK_REF_SVH

// variable string per result flag, entry 0 lands on results[23]
// character k names the bot variable that feeds top variable k
localparam logic [31:0] permOrder [permCount] = '{
    "abcd", "abdc", "acbd", "acdb", "adbc", "adcb",  // a fixed to a
    "bacd", "badc", "bcad", "bcda", "bdac", "bdca",  // b moved onto a
    "cbad", "cbda", "cabd", "cadb", "cdba", "cdab",  // c moved onto a
    "dbca", "dbac", "dcba", "dcab", "dabc", "dacb"   // d moved onto a
};

// top index reached from bot index n under permutation p
function automatic int mapIndex(input logic [31:0] p, input int n);
    int m;
    int src;
    m = n & 7;  // low three variables stay put
    for (int k = 0; k < permVars; k++) begin
        src = int'(p[31-8*k -: 8]) - 97;  // letter to variable, a is 97
        m = m | (((n >> (3 + src)) & 1) << (3 + k));
    end
    return m;
endfunction

// flag set when every set bot vector maps onto a set top vector
function automatic logic [permCount-1:0] refFlags(input truthTable_t t, input truthTable_t b,
                                                  input logic valid);
    logic [permCount-1:0] f;
    for (int idx = 0; idx < permCount; idx++) begin
        f[permCount-1-idx] = valid;
        for (int n = 0; n < tableBits; n++) begin
            if (b[n] && !t[mapIndex(permOrder[idx], n)]) begin
                f[permCount-1-idx] = 1'b0;  // bot escapes top here
            end
        end
    end
    return f;
endfunction

`endif

// File: dv/permCheckTb.sv
`default_nettype none

module permCheckTb;
    timeunit 1ns;
    timeprecision 100ps;
    import mbfPkg::*;
    import permCheckPkg::*;

    `include "permCheckRef.svh"

    localparam int singleReqs = 20;
    localparam int invalidReqs = 8;
    localparam int burstReqs = 12;
    localparam int randomReqs = 200;
    localparam int totalReqs = singleReqs + invalidReqs + 2 + burstReqs + randomReqs;
    localparam int cycleLimit = 8 * totalReqs + 200;

    logic clk;
    logic arstN;
    logic inStrobe;
    truthTable_t top;
    truthTable_t bot;
    logic botValid;
    reqTag_t inTag;
    logic full;
    logic outStrobe;
    logic [permCount-1:0] results;
    reqTag_t outTag;

    logic [31:0] lfsrState = 32'h49f2e921;
    logic [tagBits+permCount-1:0] scoreboard [$];  // tag over expected flags
    reqTag_t nextTag = '0;
    int valueErrors = 0;
    int otherErrors = 0;
    int cycles = 0;
    logic sawFull = 1'b0;

    permCheckTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);  // Galois form
    endfunction

    task automatic randomBits(input int width, output truthTable_t v);
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsrState = lfsrStep(lfsrState);  // one step per bit
            v[i] = lfsrState[0];
        end
    endtask

    function automatic truthTable_t permutedCopy(input truthTable_t t, input int idx);
        truthTable_t c;
        for (int n = 0; n < tableBits; n++) begin
            c[n] = t[mapIndex(permOrder[idx], n)];
        end
        return c;
    endfunction

    // random top and a bot below it for permutation idx
    task automatic belowPair(output truthTable_t t, output truthTable_t b, output int idx);
        truthTable_t m1;
        truthTable_t m2;
        truthTable_t r;
        randomBits(tableBits, t);
        randomBits(tableBits, m1);
        randomBits(tableBits, m2);
        randomBits(5, r);
        idx = int'(r[4:0]) % permCount;
        b = permutedCopy(t, idx) & m1 & m2;
    endtask

    task automatic sendReq(input truthTable_t t, input truthTable_t b, input logic valid);
        while (full) begin
            inStrobe = 1'b0;
            @(negedge clk);
        end
        top = t;
        bot = b;
        botValid = valid;
        inTag = nextTag;
        inStrobe = 1'b1;
        scoreboard.push_back({nextTag, refFlags(t, b, valid)});
        nextTag = nextTag + 1'b1;
        @(negedge clk);
        inStrobe = 1'b0;  // next call may raise it again in the same step
    endtask

    task automatic waitDrain();
        while (scoreboard.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic expectLow(input string name, input logic value);
        assert (value === 1'b0) else begin
            valueErrors++;
            $display("error at %0t: %s got %b expected 0", $time, name, value);
        end
    endtask

    // compare on the falling edge where outputs are settled
    always @(negedge clk) begin
        logic [tagBits+permCount-1:0] entry;
        if (full) begin
            sawFull = 1'b1;
        end
        if (arstN && outStrobe) begin
            if (scoreboard.size() == 0) begin
                otherErrors++;
                $display("result with tag %h at %0t has no pending request", outTag, $time);
            end else begin
                entry = scoreboard.pop_front();
                assert (outTag === entry[tagBits+permCount-1:permCount]) else begin
                    valueErrors++;
                    $display("error at %0t: outTag got %h expected %h", $time, outTag,
                             entry[tagBits+permCount-1:permCount]);
                end
                assert (results === entry[permCount-1:0]) else begin
                    valueErrors++;
                    $display("error at %0t: results got %h expected %h", $time, results,
                             entry[permCount-1:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout after %0d cycles, %0d results missing", cycles, scoreboard.size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        truthTable_t t;
        truthTable_t b;
        truthTable_t r;
        int idx;
        arstN = 1'b0;
        inStrobe = 1'b0;
        top = '0;
        bot = '0;
        botValid = 1'b0;
        inTag = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        repeat (20) begin  // quiet engine after reset
            @(negedge clk);
            expectLow("outStrobe", outStrobe);
            expectLow("full", full);
        end
        repeat (singleReqs) begin  // one request in flight
            belowPair(t, b, idx);
            sendReq(t, b, 1'b1);
            waitDrain();
            // the permutation that built bot has to be reported
            assert (results[permCount-1-idx] === 1'b1) else begin
                valueErrors++;
                $display("error at %0t: results[%0d] got %b expected 1", $time,
                         permCount-1-idx, results[permCount-1-idx]);
            end
        end
        repeat (invalidReqs) begin  // botValid low clears every flag
            belowPair(t, b, idx);
            sendReq(t, b, 1'b0);
            waitDrain();
        end
        randomBits(tableBits, r);
        sendReq('1, r, 1'b1);
        sendReq(r, '0, 1'b1);
        waitDrain();
        repeat (burstReqs) begin  // back to back, paced only by full
            belowPair(t, b, idx);
            sendReq(t, b, 1'b1);
        end
        waitDrain();
        assert (sawFull) else begin
            otherErrors++;
            $display("full never rose during the burst");
        end
        repeat (randomReqs) begin
            belowPair(t, b, idx);
            randomBits(3, r);
            sendReq(t, b, r[2] | r[1]);  // botValid mostly high
            randomBits(2, r);
            repeat (int'(r[1:0])) @(negedge clk);
        end
        waitDrain();
        repeat (8) @(negedge clk);  // catch stray strobes
        $display("checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: permCheck.f
+incdir+dv
hw/mbfPkg.sv
hw/permCheckPkg.sv
hw/permIntermediaryIf.sv
hw/permIntermediaryProducer.sv
hw/permIntermediaryQueue.sv
hw/permResultConsumer.sv
hw/permCheckTop.sv
dv/permCheckTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the permutation check testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f permCheck.f \
    --top-module permCheckTb -Mdir "$BUILD_DIR" -o permCheckSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/permCheckSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
